/* list.f */
+incdir+include
source/prbs_cfg_pkg.sv
source/prbs_stat_pkg.sv
source/prbs_checker_core.sv
source/sym_prbs_checker.sv
source/prbs_pattern_gen.sv
source/prbs_test_ctrl.sv
source/prbs_test_top.sv
tb/prbs_test_assert.sv
tb/prbs_test_tb.sv

/* run.sh */
#!/bin/sh
# builds the PRBS link test with Verilator and runs it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f \
    --top-module prbs_test_tb -o prbs_test_sim &&
./obj_dir/prbs_test_sim ||
{ echo "PRBS link test simulation did not complete cleanly"; exit 1; }

/* tb/prbs_test_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "prbs_consts.svh"

module prbs_test_tb;

    import prbs_cfg_pkg::*;
    import prbs_stat_pkg::*;

    localparam int max_wait = 4096;

    logic        clk;
    logic        reset;
    prbs_cfg_t   cfg;
    logic        start;
    logic [31:0] test_len;
    inject_t     inject;
    prbs_stat_t  stat;
    logic        busy;
    logic        done;
    logic [31:0] lcg_state = 32'hbc61fdb4;

    prbs_test_top dut (
        .clk      (clk),
        .reset    (reset),
        .cfg      (cfg),
        .start    (start),
        .test_len (test_len),
        .inject   (inject),
        .stat     (stat),
        .busy     (busy),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int count_ones(input logic [31:0] v);
        int c;
        c = 0;
        for (int i = 0; i < 32; i++) begin
            c += int'(v[i]);
        end
        return c;
    endfunction

    // bits checked over a whole test
    function automatic logic [63:0] expected_total(input logic [31:0] len,
                                                   input logic [15:0] mask);
        return 64'(len) * 64'(`PRBS_SYM_BITS * count_ones({16'd0, mask}));
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic set_cfg(input logic [15:0] mask, input logic inv_pred);
        @(posedge clk);
        cfg <= '{eqn: `PRBS_TAPS_DEFAULT, chan_sel: mask, inv_rx: 1'b0, inv_pred: inv_pred};
    endtask

    // cycle n counts from the start cycle; negative cycle numbers are unused
    task automatic run_test(input logic [31:0] len, input int inject_at,
                            input logic [4:0] lane, input int extra_start_at);
        int n;
        int done_at;
        done_at = 2 + `PRBS_ALIGN_CYCLES + int'(len);
        @(posedge clk);
        start       <= 1'b1;
        test_len    <= len;
        inject.lane <= lane;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            start         <= (n == extra_start_at);
            inject.strobe <= (n == inject_at);
            @(negedge clk);
            check_value("busy during test", 64'(busy), 64'd1);
            check_value("done", 64'(done), 64'(n == done_at));
        end while (!done && n < max_wait);
        if (!done) begin
            $display("timeout: done never arrived within %0d cycles of start", max_wait);
            $display("=== FAIL ===");
            $fatal(1, "timeout waiting for done");
        end
    endtask

    task automatic check_idle(input logic [63:0] err_exp, input logic [63:0] tot_exp);
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            check_value("busy after done", 64'(busy), 64'd0);
        end
        check_value("held err_bits", stat.err_bits, err_exp);
        check_value("held total_bits", stat.total_bits, tot_exp);
    endtask

    task automatic test_clean_all();
        logic [31:0] len;
        len = 32'd16 + (next_random() % 32'd64);
        set_cfg(16'hffff, 1'b0);
        run_test(len, -1, 5'd0, -1);
        check_value("clean err_bits", stat.err_bits, 64'd0);
        check_value("clean total_bits", stat.total_bits, expected_total(len, 16'hffff));
    endtask

    task automatic test_random_mask();
        logic [31:0] len;
        logic [31:0] r;
        logic [15:0] mask;
        len  = 32'd8 + (next_random() % 32'd100);
        r    = next_random();
        mask = (r[15:0] == 16'd0) ? 16'h0001 : r[15:0];
        set_cfg(mask, 1'b0);
        run_test(len, -1, 5'd0, -1);
        check_value("masked err_bits", stat.err_bits, 64'd0);
        check_value("masked total_bits", stat.total_bits, expected_total(len, mask));
    endtask

    // one flipped bit plus one error per later tap that uses it
    task automatic test_inject_selected();
        logic [31:0] len;
        logic [31:0] r;
        logic [4:0]  lane;
        logic [15:0] mask;
        len  = 32'd40 + (next_random() % 32'd32);
        r    = next_random();
        lane = r[4:0];
        mask = r[31:16] | (16'd1 << lane[3:0]);
        set_cfg(mask, 1'b0);
        run_test(len, 2 + `PRBS_ALIGN_CYCLES + int'(len / 32'd2), lane, -1);
        check_value("injected err_bits", stat.err_bits,
                    64'(count_ones(`PRBS_TAPS_DEFAULT) + 1));
        check_value("injected total_bits", stat.total_bits, expected_total(len, mask));
    endtask

    task automatic test_inject_ignored();
        logic [31:0] len;
        logic [31:0] r;
        logic [4:0]  lane;
        logic [15:0] mask;
        len  = 32'd40 + (next_random() % 32'd32);
        r    = next_random();
        lane = r[4:0];
        mask = ~(16'd1 << lane[3:0]);
        // channel of the flipped lane is left out
        set_cfg(mask, 1'b0);
        run_test(len, 2 + `PRBS_ALIGN_CYCLES + int'(len / 32'd2), lane, -1);
        check_value("deselected err_bits", stat.err_bits, 64'd0);
        check_value("deselected total_bits", stat.total_bits, expected_total(len, mask));
        // a flip during align is flushed before counting starts
        set_cfg(16'hffff, 1'b0);
        run_test(len, 10, lane, -1);
        check_value("align inject err_bits", stat.err_bits, 64'd0);
        check_value("align inject total_bits", stat.total_bits, expected_total(len, 16'hffff));
    endtask

    task automatic test_inverted_prediction();
        logic [31:0] len;
        logic [31:0] r;
        logic [15:0] mask;
        len  = 32'd16 + (next_random() % 32'd48);
        r    = next_random();
        mask = r[15:0] | 16'h0001;
        set_cfg(mask, 1'b1);
        run_test(len, -1, 5'd0, -1);
        check_value("inverted total_bits", stat.total_bits, expected_total(len, mask));
        check_value("inverted err_bits", stat.err_bits, expected_total(len, mask));
        set_cfg(16'hffff, 1'b0);
    endtask

    task automatic test_back_to_back();
        logic [31:0] len_a;
        logic [31:0] len_b;
        logic [31:0] r;
        logic [15:0] mask_b;
        len_a = 32'd16 + (next_random() % 32'd64);
        len_b = 32'd16 + (next_random() % 32'd64);
        r      = next_random();
        mask_b = r[15:0] | 16'h8000;
        set_cfg(16'hffff, 1'b0);
        // second start lands in the align phase
        run_test(len_a, -1, 5'd0, 20);
        check_value("first total_bits", stat.total_bits, expected_total(len_a, 16'hffff));
        check_idle(64'd0, expected_total(len_a, 16'hffff));
        set_cfg(mask_b, 1'b0);
        run_test(len_b, -1, 5'd0, -1);
        check_value("second err_bits", stat.err_bits, 64'd0);
        check_value("second total_bits", stat.total_bits, expected_total(len_b, mask_b));
    endtask

    initial begin
        reset    <= 1'b1;
        start    <= 1'b0;
        test_len <= '0;
        inject   <= '0;
        // taps are valid before the generator leaves reset
        cfg      <= '{eqn: `PRBS_TAPS_DEFAULT, chan_sel: 16'hffff,
                      inv_rx: 1'b0, inv_pred: 1'b0};
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("busy after reset", 64'(busy), 64'd0);
        check_value("done after reset", 64'(done), 64'd0);
        check_value("err_bits after reset", stat.err_bits, 64'd0);
        check_value("total_bits after reset", stat.total_bits, 64'd0);
        test_clean_all();
        test_random_mask();
        test_inject_selected();
        test_inject_ignored();
        test_inverted_prediction();
        test_back_to_back();
        check_value("assertion failures", 64'(dut.u_assert.fail_count), 64'd0);
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/prbs_test_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module prbs_test_assert (
    input wire logic                        clk,
    input wire logic                        reset,
    input wire prbs_cfg_pkg::checker_mode_e mode,
    input wire logic                        busy,
    input wire logic                        done,
    input wire prbs_stat_pkg::prbs_stat_t   stat
);

    import prbs_cfg_pkg::*;

    int fail_count = 0;

    // reset mode only in the clear cycle that follows idle
    a_reset_clear: assert property (@(posedge clk) disable iff (reset)
        (mode == MODE_RESET) |-> (busy && !done && $past(!busy)))
        else begin
            fail_count++;
            $error("counter clear outside the clear state");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else begin
            fail_count++;
            $error("done longer than one cycle");
        end

    // total count only drops through a clear
    a_total_mono: assert property (@(posedge clk) disable iff (reset)
        (mode != MODE_RESET) |=> (stat.total_bits >= $past(stat.total_bits)))
        else begin
            fail_count++;
            $error("total_bits decreased without a clear");
        end

endmodule

bind prbs_test_top prbs_test_assert u_assert (
    .clk   (clk),
    .reset (reset),
    .mode  (mode),
    .busy  (busy),
    .done  (done),
    .stat  (stat)
);

`default_nettype wire

/* source/prbs_test_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "prbs_consts.svh"

module prbs_test_top (
    input wire logic                    clk,
    input wire logic                    reset,
    input wire prbs_cfg_pkg::prbs_cfg_t cfg,
    input wire logic                    start,
    input wire logic [31:0]             test_len,
    input wire prbs_stat_pkg::inject_t  inject,
    output prbs_stat_pkg::prbs_stat_t   stat,
    output logic                        busy,
    output logic                        done
);

    import prbs_cfg_pkg::*;

    logic [`PRBS_SYM_BITS-1:0] tx_syms [`PRBS_CHANNELS];
    checker_mode_e             mode;

    prbs_pattern_gen u_gen (
        .clk     (clk),
        .reset   (reset),
        .eqn     (cfg.eqn),
        .inject  (inject),
        .tx_syms (tx_syms)
    );

    // lane flags are not brought out
    sym_prbs_checker u_checker (
        .clk     (clk),
        .reset   (reset),
        .cfg     (cfg),
        .mode    (mode),
        .rx_syms (tx_syms),
        .stat    (stat),
        .flags   ()
    );

    prbs_test_ctrl u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .test_len (test_len),
        .mode     (mode),
        .busy     (busy),
        .done     (done)
    );

endmodule

`default_nettype wire

/* source/prbs_test_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "prbs_consts.svh"

module prbs_test_ctrl (
    input wire logic                    clk,
    input wire logic                    reset,
    input wire logic                    start,
    input wire logic [31:0]             test_len,
    output prbs_cfg_pkg::checker_mode_e mode,
    output logic                        busy,
    output logic                        done
);

    import prbs_cfg_pkg::*;

    ctrl_state_e state;
    logic [31:0] len_q;
    // shared by align and test phases
    logic [31:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            len_q <= '0;
            count <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        len_q <= test_len;
                        state <= ST_CLEAR;
                    end
                end
                ST_CLEAR: begin
                    count <= 32'(`PRBS_ALIGN_CYCLES - 1);
                    state <= ST_ALIGN;
                end
                ST_ALIGN: begin
                    if (count == '0) begin
                        // zero length skips straight to done
                        if (len_q == '0) begin
                            state <= ST_DONE;
                        end else begin
                            count <= len_q - 32'd1;
                            state <= ST_TEST;
                        end
                    end else begin
                        count <= count - 32'd1;
                    end
                end
                ST_TEST: begin
                    if (count == '0) begin
                        state <= ST_DONE;
                    end else begin
                        count <= count - 32'd1;
                    end
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // checker mode per state; idle and done freeze the counts
    always_comb begin
        case (state)
            ST_CLEAR: mode = MODE_RESET;
            ST_ALIGN: mode = MODE_ALIGN;
            ST_TEST:  mode = MODE_TEST;
            default:  mode = MODE_FREEZE;
        endcase
    end

    assign busy = (state != ST_IDLE);
    assign done = (state == ST_DONE);

endmodule

`default_nettype wire

/* source/prbs_pattern_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "prbs_consts.svh"

module prbs_pattern_gen (
    input wire logic                    clk,
    input wire logic                    reset,
    input wire logic [`PRBS_N-1:0]      eqn,
    input wire prbs_stat_pkg::inject_t  inject,
    output logic [`PRBS_SYM_BITS-1:0]   tx_syms [`PRBS_CHANNELS]
);

    localparam int n_lanes = `PRBS_CHANNELS * `PRBS_SYM_BITS;

    // lfsr[0] holds the most recent sequence bit
    logic [`PRBS_N-1:0] lfsr;
    logic [`PRBS_N-1:0] lfsr_next;
    logic [n_lanes-1:0] word_next;
    logic [n_lanes-1:0] flip;
    logic [n_lanes-1:0] word_q;

    // unrolled 32 steps per clock, bit k of the word is step k
    always_comb begin
        lfsr_next = lfsr;
        word_next = '0;
        for (int k = 0; k < n_lanes; k++) begin
            word_next[k] = ^(lfsr_next & eqn);
            lfsr_next    = {lfsr_next[`PRBS_N-2:0], word_next[k]};
        end
    end

    // single-bit error mask, output word only
    assign flip = inject.strobe ? (n_lanes'(1) << inject.lane) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= '1;
        end else begin
            lfsr <= lfsr_next;
        end
    end

    always_ff @(posedge clk) begin
        word_q <= word_next ^ flip;
    end

    // lane b*channels+ch goes to bit b of channel ch
    always_comb begin
        for (int b = 0; b < `PRBS_SYM_BITS; b++) begin
            for (int ch = 0; ch < `PRBS_CHANNELS; ch++) begin
                tx_syms[ch][b] = word_q[b*`PRBS_CHANNELS + ch];
            end
        end
    end

endmodule

`default_nettype wire

/* source/sym_prbs_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "prbs_consts.svh"

module sym_prbs_checker #(
    parameter int n_channels   = `PRBS_CHANNELS,
    parameter int sym_bitwidth = `PRBS_SYM_BITS
) (
    input wire logic                       clk,
    input wire logic                       reset,
    input wire prbs_cfg_pkg::prbs_cfg_t    cfg,
    input wire prbs_cfg_pkg::checker_mode_e mode,
    input wire logic [sym_bitwidth-1:0]    rx_syms [n_channels],
    output prbs_stat_pkg::prbs_stat_t      stat,
    output logic [n_channels*sym_bitwidth-1:0] flags
);

    import prbs_cfg_pkg::*;

    localparam int n_lanes = n_channels * sym_bitwidth;
    localparam int cnt_w   = $clog2(n_lanes) + 1;

    logic [n_lanes-1:0] rx_bits;
    logic [cnt_w-1:0]   err_count;
    logic [cnt_w-1:0]   tot_count;
    logic [63:0]        err_acc;
    logic [63:0]        tot_acc;

    // lane b*n_channels+ch carries bit b of channel ch
    always_comb begin
        for (int b = 0; b < sym_bitwidth; b++) begin
            for (int ch = 0; ch < n_channels; ch++) begin
                rx_bits[b*n_channels + ch] = rx_syms[ch][b];
            end
        end
    end

    // one checker per lane, all sharing the full tap mask
    for (genvar k = 0; k < n_lanes; k++) begin : g_lane
        prbs_checker_core u_core (
            .clk      (clk),
            .reset    (reset),
            .eqn      (cfg.eqn),
            .inv_rx   (cfg.inv_rx),
            .inv_pred (cfg.inv_pred),
            .rx_bit   (rx_bits[k]),
            .err      (flags[k])
        );
    end

    // per-cycle sums over selected channels
    always_comb begin
        err_count = '0;
        tot_count = '0;
        for (int ch = 0; ch < n_channels; ch++) begin
            if (cfg.chan_sel[ch]) begin
                tot_count = tot_count + cnt_w'(sym_bitwidth);
                for (int b = 0; b < sym_bitwidth; b++) begin
                    err_count = err_count + cnt_w'(flags[b*n_channels + ch]);
                end
            end
        end
    end

    // accumulate by mode; align and freeze hold
    always_ff @(posedge clk) begin
        if (reset) begin
            err_acc <= '0;
            tot_acc <= '0;
        end else begin
            case (mode)
                MODE_RESET: begin
                    err_acc <= '0;
                    tot_acc <= '0;
                end
                MODE_TEST: begin
                    err_acc <= err_acc + 64'(err_count);
                    tot_acc <= tot_acc + 64'(tot_count);
                end
                default: begin
                    err_acc <= err_acc;
                    tot_acc <= tot_acc;
                end
            endcase
        end
    end

    assign stat.err_bits   = err_acc;
    assign stat.total_bits = tot_acc;

endmodule

`default_nettype wire

/* source/prbs_checker_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "prbs_consts.svh"

module prbs_checker_core (
    input wire logic               clk,
    input wire logic               reset,
    input wire logic [`PRBS_N-1:0] eqn,
    input wire logic               inv_rx,
    input wire logic               inv_pred,
    input wire logic               rx_bit,
    output logic                   err
);

    // hist[0] is the sample one cycle back
    logic [`PRBS_N-1:0] hist;
    logic               rx_val;
    logic               pred;

    assign rx_val = rx_bit ^ inv_rx;

    // prediction from the tapped history samples
    assign pred = (^(hist & eqn)) ^ inv_pred;

    // history is fed from received data so the core locks on its own
    always_ff @(posedge clk) begin
        if (reset) begin
            hist <= '0;
            err  <= 1'b0;
        end else begin
            hist <= {hist[`PRBS_N-2:0], rx_val};
            err  <= rx_val ^ pred;
        end
    end

endmodule

`default_nettype wire

/* source/prbs_stat_pkg.sv */
`default_nettype none

package prbs_stat_pkg;

    `include "prbs_consts.svh"

    // request to flip one lane of the next generated word
    typedef struct packed {
        logic                                               strobe;
        logic [$clog2(`PRBS_CHANNELS*`PRBS_SYM_BITS)-1:0]   lane;
    } inject_t;

    // accumulated checker results
    typedef struct packed {
        logic [63:0] err_bits;
        logic [63:0] total_bits;
    } prbs_stat_t;

endpackage

`default_nettype wire

/* source/prbs_cfg_pkg.sv */
`default_nettype none

package prbs_cfg_pkg;

    `include "prbs_consts.svh"

    // checker accumulation mode
    typedef enum logic [1:0] {
        MODE_RESET  = 2'b00,
        MODE_ALIGN  = 2'b01,
        MODE_TEST   = 2'b10,
        MODE_FREEZE = 2'b11
    } checker_mode_e;

    // test sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_ALIGN,
        ST_TEST,
        ST_DONE
    } ctrl_state_e;

    // eqn bit i taps the sample i+1 cycles back in the same lane
    typedef struct packed {
        logic [`PRBS_N-1:0]        eqn;
        logic [`PRBS_CHANNELS-1:0] chan_sel;
        logic                      inv_rx;
        logic                      inv_pred;
    } prbs_cfg_t;

endpackage

`default_nettype wire

/* include/prbs_consts.svh */
`ifndef PRBS_CONSTS_SVH
`define PRBS_CONSTS_SVH

// length of the checker history and width of the tap mask
`define PRBS_N 32

// receiver geometry
`define PRBS_CHANNELS 16
`define PRBS_SYM_BITS 2

// cycles spent in the align phase
// must exceed PRBS_N plus the generator and checker pipeline
`define PRBS_ALIGN_CYCLES 40

// PRBS7 taps, samples 6 and 7 back
`define PRBS_TAPS_DEFAULT 32'h0000_0060

`endif
